// File: verilog/fetch_defs.svh
// all widths assume a 32-bit instruction bus and the FIFO depth must stay at 3 or more
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

////////////////////////////////////////////////////////////
// fetch path sizing
////////////////////////////////////////////////////////////

// byte address width of the instruction bus
`define FETCH_ADDR_W 32

// width of one memory word, also the widest instruction
`define FETCH_DATA_W 32

// words held in the prefetch queue
// a misaligned 32-bit instruction needs two words plus one slot for the access in flight
`define FETCH_FIFO_DEPTH 3

`endif

// File: verilog/fetch_pkg.sv
// bus and output types of the fetch path, sized by the defs header and only for 32-bit words
`include "fetch_defs.svh"

package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // instruction memory bus
  ////////////////////////////////////////////////////////////

  // request toward memory, held until gnt
  typedef struct packed {
    logic                     req;
    // always word aligned
    logic [`FETCH_ADDR_W-1:0] addr;
  } instr_req_t;

  // answer from memory
  typedef struct packed {
    logic                     gnt;
    // comes with gnt, no rvalid follows it
    logic                     err;
    logic                     rvalid;
    logic [`FETCH_DATA_W-1:0] rdata;
  } instr_rsp_t;

  ////////////////////////////////////////////////////////////
  // core side
  ////////////////////////////////////////////////////////////

  // one instruction as handed to the core
  typedef struct packed {
    // upper half is zero for a compressed instruction
    logic [`FETCH_DATA_W-1:0] instr;
    // halfword address of the first byte
    logic [`FETCH_ADDR_W-1:0] addr;
    logic                     is_compressed;
  } fetch_out_t;

  // memory-side fetch FSM
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED,
    WAIT_ERR
  } pf_state_e;

endpackage

// File: verilog/fetch_fifo.sv
// word queue with a shifting head and DEPTH of 3 or more, entries past the head must be sequential
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_fifo import fetch_pkg::*; #(
  parameter int DEPTH = `FETCH_FIFO_DEPTH
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // empties the queue at the next edge
  input  logic                     clear_i,

  // word side, written by the fetch FSM
  input  logic                     in_valid_i,
  input  logic [`FETCH_ADDR_W-1:0] in_addr_i,
  input  logic [`FETCH_DATA_W-1:0] in_rdata_i,
  output logic                     in_ready_o,

  // instruction side, toward the core
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output fetch_out_t               out_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  // entry 0 is the head, its address carries the halfword offset of the next instruction
  logic [`FETCH_DATA_W-1:0] rdata_q [DEPTH];
  logic [`FETCH_DATA_W-1:0] rdata_n [DEPTH];
  logic [`FETCH_ADDR_W-1:0] addr_q [DEPTH];
  logic [`FETCH_ADDR_W-1:0] addr_n [DEPTH];
  logic [CNT_W-1:0]         count_q;
  logic [CNT_W-1:0]         count_n;

  logic                     head_odd;
  logic [15:0]              head_half;
  logic                     head_short;
  logic                     consume;

  ////////////////////////////////////////////////////////////
  // head decode
  ////////////////////////////////////////////////////////////

  // instruction starts in the upper half of the head word
  assign head_odd   = addr_q[0][1];
  assign head_half  = head_odd ? rdata_q[0][31:16] : rdata_q[0][15:0];
  // anything but 11 in the low bits is a 16-bit encoding
  assign head_short = (head_half[1:0] != 2'b11);

  // one word is enough unless a full instruction spills into the next entry
  assign out_valid_o = (count_q != '0) &&
                       (head_short || !head_odd || (count_q > CNT_W'(1)));

  assign consume = out_valid_o && out_ready_i;

  always_comb begin
    out_o.addr          = addr_q[0];
    out_o.is_compressed = head_short;
    if (head_short) begin
      out_o.instr = {16'h0000, head_half};
    end else if (head_odd) begin
      // upper half of the head joined with the lower half of the next word
      out_o.instr = {rdata_q[1][15:0], head_half};
    end else begin
      out_o.instr = rdata_q[0];
    end
  end

  // two free slots, one for a word arriving now and one for the next access
  assign in_ready_o = (count_q < CNT_W'(DEPTH - 1));

  ////////////////////////////////////////////////////////////
  // advance, push and clear
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata_n = rdata_q;
    addr_n  = addr_q;
    count_n = count_q;

    if (consume) begin
      if (head_short && !head_odd) begin
        // lower half used, the upper half is next
        addr_n[0][1] = 1'b1;
      end else begin
        // head word used up, shift everything down by one
        for (int i = 0; i < DEPTH - 1; i++) begin
          rdata_n[i] = rdata_q[i + 1];
          addr_n[i]  = addr_q[i + 1];
        end
        count_n = count_q - 1'b1;
        // a misaligned full instruction also took the lower half of the next word
        if (!head_short && head_odd) begin
          addr_n[0][1] = 1'b1;
        end
      end
    end

    // new word goes behind whatever is left after the pop
    if (in_valid_i) begin
      rdata_n[count_n] = in_rdata_i;
      addr_n[count_n]  = in_addr_i;
      count_n          = count_n + 1'b1;
    end

    // branch flush wins over everything else
    if (clear_i) begin
      count_n = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_n;
    end
  end

  // entries beyond count_q are don't care
  always_ff @(posedge clk) begin
    rdata_q <= rdata_n;
    addr_q  <= addr_n;
  end

endmodule

// File: verilog/prefetch_buffer.sv
// a branch always fetches its target while req_i only gates the sequential fetches after it
`timescale 1ns/1ps
`include "fetch_defs.svh"

module prefetch_buffer import fetch_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,

  // core control
  input  logic                     req_i,
  input  logic                     branch_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,

  // instruction stream
  input  logic                     ready_i,
  output logic                     valid_o,
  output fetch_out_t               out_o,

  // instruction memory
  output instr_req_t               mem_req_o,
  input  instr_rsp_t               mem_rsp_i,

  // status
  output logic                     fetch_failed_o,
  output logic                     busy_o
);

  pf_state_e                state_q;
  pf_state_e                state_n;
  // where the next state goes once a request is raised this cycle
  pf_state_e                issue_ns;

  // last requested address, keeps the halfword offset of a branch target
  logic [`FETCH_ADDR_W-1:0] addr_q;
  logic [`FETCH_ADDR_W-1:0] fetch_addr;
  logic                     addr_valid;
  logic                     start_fetch;

  logic                     fifo_push;
  logic                     fifo_ready;

  ////////////////////////////////////////////////////////////
  // word queue
  ////////////////////////////////////////////////////////////

  // pushed words are tagged with the address they were requested at
  fetch_fifo u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (branch_i),
    .in_valid_i  (fifo_push),
    .in_addr_i   (addr_q),
    .in_rdata_i  (mem_rsp_i.rdata),
    .in_ready_o  (fifo_ready),
    .out_valid_o (valid_o),
    .out_ready_i (ready_i),
    .out_o       (out_o)
  );

  ////////////////////////////////////////////////////////////
  // fetch FSM
  ////////////////////////////////////////////////////////////

  // next sequential word after the last request
  assign fetch_addr = {addr_q[`FETCH_ADDR_W-1:2] + 1'b1, 2'b00};

  // the queue has been flushed on a branch so room is guaranteed
  assign start_fetch = branch_i || (req_i && fifo_ready);

  // an err grant refuses the access, no rvalid comes for it
  assign issue_ns = !mem_rsp_i.gnt ? WAIT_GNT : (mem_rsp_i.err ? WAIT_ERR : WAIT_RVALID);

  always_comb begin
    state_n        = state_q;
    mem_req_o.req  = 1'b0;
    mem_req_o.addr = fetch_addr;
    addr_valid     = 1'b0;
    fifo_push      = 1'b0;
    fetch_failed_o = 1'b0;

    unique case (state_q)
      // nothing in flight
      IDLE: begin
        if (start_fetch) begin
          mem_req_o.req = 1'b1;
          addr_valid    = 1'b1;
          state_n       = issue_ns;
        end
      end

      // request raised, hold it until gnt
      WAIT_GNT: begin
        mem_req_o.req  = 1'b1;
        mem_req_o.addr = {addr_q[`FETCH_ADDR_W-1:2], 2'b00};
        addr_valid     = branch_i;
        state_n        = issue_ns;
      end

      // granted, the next request can go out with the rvalid
      WAIT_RVALID: begin
        if (mem_rsp_i.rvalid) begin
          // a word from the old path is dropped on a branch
          fifo_push = !branch_i;
          if (start_fetch) begin
            mem_req_o.req = 1'b1;
            addr_valid    = 1'b1;
            state_n       = issue_ns;
          end else begin
            state_n = IDLE;
          end
        end else if (branch_i) begin
          // old response still coming, swallow it first
          addr_valid = 1'b1;
          state_n    = WAIT_ABORTED;
        end
      end

      // stale rvalid pending, target already in addr_q
      WAIT_ABORTED: begin
        mem_req_o.addr = {addr_q[`FETCH_ADDR_W-1:2], 2'b00};
        addr_valid     = branch_i;
        if (mem_rsp_i.rvalid) begin
          mem_req_o.req = 1'b1;
          state_n       = issue_ns;
        end
      end

      // refused access, only a branch gets out of here
      WAIT_ERR: begin
        // words ahead of the failing one are still handed out first
        fetch_failed_o = !valid_o && !branch_i;
        if (branch_i) begin
          mem_req_o.req = 1'b1;
          addr_valid    = 1'b1;
          state_n       = issue_ns;
        end
      end

      default: begin
        state_n = IDLE;
      end
    endcase

    // branch target goes out in the same cycle, rounded down to its word
    if (branch_i) begin
      mem_req_o.addr = {branch_addr_i[`FETCH_ADDR_W-1:2], 2'b00};
    end
  end

  assign busy_o = (state_q != IDLE) || mem_req_o.req;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_n;
      // full branch address kept so the queue starts at the right halfword
      if (addr_valid) begin
        addr_q <= branch_i ? branch_addr_i : mem_req_o.addr;
      end
    end
  end

endmodule

// File: verilog/if_stage.sv
// fetch front end for one outstanding access, the core must branch to its start address first
`timescale 1ns/1ps
`include "fetch_defs.svh"

module if_stage import fetch_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,

  ////////////////////////////////////////////////////////////
  // core port
  ////////////////////////////////////////////////////////////

  // fetching allowed
  input  logic                     req_i,
  // one-cycle redirect, target may be halfword aligned
  input  logic                     branch_i,
  input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,

  // valid/ready handshake, out_o holds while stalled
  input  logic                     ready_i,
  output logic                     valid_o,
  output fetch_out_t               out_o,

  // high after a refused access until the next branch
  output logic                     fetch_failed_o,
  // anything in flight or being requested
  output logic                     busy_o,

  ////////////////////////////////////////////////////////////
  // instruction memory port
  ////////////////////////////////////////////////////////////

  // req/gnt/rvalid, responses in order
  output instr_req_t               instr_req_o,
  input  instr_rsp_t               instr_rsp_i
);

  // fetch FSM and queue, default depth
  prefetch_buffer u_prefetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .out_o          (out_o),
    .mem_req_o      (instr_req_o),
    .mem_rsp_i      (instr_rsp_i),
    .fetch_failed_o (fetch_failed_o),
    .busy_o         (busy_o)
  );

endmodule

// File: verification/instr_mem_model.sv
// 4 KiB aliased halfword memory, one access outstanding, err window compares the low 12 address bits
`timescale 1ns/1ps
`include "fetch_defs.svh"

module instr_mem_model import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  instr_req_t req_i,
  output instr_rsp_t rsp_o,
  // refused byte range, lo inclusive and hi exclusive
  input  logic [11:0] err_lo_i,
  input  logic [11:0] err_hi_i
);

  // halfword contents, index is addr[11:1]
  logic [15:0]              mem [2048];

  logic [1:0]               gnt_wait_q;
  logic [1:0]               rv_wait_q;
  logic                     pend_q;
  logic [`FETCH_ADDR_W-1:0] addr_q;
  logic                     rvalid_q;
  logic [`FETCH_DATA_W-1:0] rdata_q;
  logic                     gnt;
  logic                     in_window;

  // random halfwords, roughly a third carry a 16-bit encoding
  task automatic fill_random();
    logic [15:0] h;
    for (int i = 0; i < 2048; i++) begin
      h = 16'($urandom);
      if ($urandom % 3 == 0) begin
        h[1:0] = 2'($urandom % 3);
      end else begin
        h[1:0] = 2'b11;
      end
      mem[i] = h;
    end
  endtask

  assign in_window = (req_i.addr[11:0] >= err_lo_i) && (req_i.addr[11:0] < err_hi_i);
  // grant only when the previous response is out or leaving now
  assign gnt = req_i.req && (gnt_wait_q == 2'd0) && (!pend_q || rvalid_q);

  always_comb begin
    rsp_o.gnt    = gnt;
    rsp_o.err    = gnt && in_window;
    rsp_o.rvalid = rvalid_q;
    rsp_o.rdata  = rdata_q;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_wait_q <= 2'd0;
      rv_wait_q  <= 2'd0;
      pend_q     <= 1'b0;
      addr_q     <= '0;
    end else begin
      if (pend_q && rvalid_q) begin
        pend_q <= 1'b0;
      end else if (pend_q && rv_wait_q != 2'd0) begin
        rv_wait_q <= rv_wait_q - 2'd1;
      end
      // grant delay only runs down while a request is up
      if (req_i.req && !gnt && gnt_wait_q != 2'd0) begin
        gnt_wait_q <= gnt_wait_q - 2'd1;
      end
      if (gnt) begin
        gnt_wait_q <= 2'($urandom % 4);
        // refused accesses get no response
        if (!in_window) begin
          pend_q    <= 1'b1;
          rv_wait_q <= 2'($urandom % 4);
          addr_q    <= req_i.addr;
        end
      end
    end
  end

  // response driven on the falling edge, one or more cycles after gnt
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= pend_q && (rv_wait_q == 2'd0);
      rdata_q  <= {mem[{addr_q[11:2], 1'b1}], mem[{addr_q[11:2], 1'b0}]};
    end
  end

endmodule

// File: verification/tb_if_stage.sv
// random fetch streams against a PC model, stops at the first error, run length bounded by cycles
`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_if_stage import fetch_pkg::*; ();

  // accepted instructions per test, these size the timeout
  localparam int N_SEQ   = 200;
  localparam int N_MIS   = 160;
  localparam int N_ABORT = 300;
  localparam int N_BP    = 200;
  localparam int N_ERR   = 60;
  localparam int N_IDLE  = 4;
  localparam int LIMIT   = (N_SEQ + N_MIS + N_ABORT + N_BP + N_ERR + N_IDLE) * 12;

  logic                     clk;
  logic                     rst_n;
  logic                     req;
  logic                     branch;
  logic [`FETCH_ADDR_W-1:0] branch_addr;
  logic                     ready;
  logic                     valid;
  fetch_out_t               out;
  logic                     fetch_failed;
  logic                     busy;
  instr_req_t               instr_req;
  instr_rsp_t               instr_rsp;
  logic [11:0]              err_lo;
  logic [11:0]              err_hi;

  // reference state
  logic [`FETCH_ADDR_W-1:0] pc;
  int                       accepted;
  int                       cycles;
  string                    test_name;
  logic                     stall_q;
  fetch_out_t               hold_q;
  fetch_out_t               exp_out;

  if_stage u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .ready_i        (ready),
    .valid_o        (valid),
    .out_o          (out),
    .fetch_failed_o (fetch_failed),
    .busy_o         (busy),
    .instr_req_o    (instr_req),
    .instr_rsp_i    (instr_rsp)
  );

  instr_mem_model u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req),
    .rsp_o    (instr_rsp),
    .err_lo_i (err_lo),
    .err_hi_i (err_hi)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // reference model and compare tasks
  ////////////////////////////////////////////////////////////

  // instruction that starts at pc, read straight from the memory array
  function automatic fetch_out_t expect_at(input logic [`FETCH_ADDR_W-1:0] pc_i);
    logic [10:0] idx;
    logic [15:0] lo;
    logic [15:0] hi;
    fetch_out_t  e;
    idx = pc_i[11:1];
    lo  = u_mem.mem[idx];
    hi  = u_mem.mem[idx + 11'd1];
    e.addr          = pc_i;
    e.is_compressed = (lo[1:0] != 2'b11);
    e.instr         = e.is_compressed ? {16'h0000, lo} : {hi, lo};
    return e;
  endfunction

  task automatic check_out(input fetch_out_t exp, input fetch_out_t act);
    if (exp !== act) begin
      $display("Mismatch in %s: expected addr %h instr %h c %b, actual addr %h instr %h c %b",
               test_name, exp.addr, exp.instr, exp.is_compressed,
               act.addr, act.instr, act.is_compressed);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch in %s (%s): expected %b, actual %b", test_name, what, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // every handshake is checked against the PC, a branch then moves the PC
  always @(posedge clk) begin
    if (rst_n) begin
      if (stall_q) begin
        check_out(hold_q, out);
        check_flag("valid_o held", 1'b1, valid);
      end
      if (valid && ready) begin
        exp_out = expect_at(pc);
        check_out(exp_out, out);
        pc = pc + (exp_out.is_compressed ? 32'd2 : 32'd4);
        accepted++;
      end
      if (branch) begin
        pc = branch_addr;
      end
      stall_q = valid && !ready && !branch;
      hold_q  = out;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("Test failures found");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // one-cycle pulse, the next driver clears it
  task automatic branch_to(input logic [`FETCH_ADDR_W-1:0] target);
    @(negedge clk);
    branch      = 1'b1;
    branch_addr = target;
  endtask

  // ready_pct in percent, branch_per of 0 means no random branches
  task automatic run_stream(input int n, input int ready_pct, input int branch_per);
    int start;
    start = accepted;
    while (accepted - start < n) begin
      @(negedge clk);
      ready  = ($urandom % 100) < ready_pct;
      branch = 1'b0;
      if (branch_per != 0 && ($urandom % branch_per) == 0) begin
        branch      = 1'b1;
        branch_addr = ($urandom % 2048) * 2;
      end
    end
    @(negedge clk);
    branch = 1'b0;
  endtask

  initial begin
    void'($urandom(32'hcee2_2047));
    rst_n       = 1'b0;
    req         = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    ready       = 1'b0;
    err_lo      = 12'h000;
    err_hi      = 12'h000;
    pc          = '0;
    accepted    = 0;
    cycles      = 0;
    stall_q     = 1'b0;
    u_mem.fill_random();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    test_name = "reset";
    @(negedge clk);
    check_flag("valid_o", 1'b0, valid);
    check_flag("fetch_failed_o", 1'b0, fetch_failed);
    check_flag("busy_o", 1'b0, busy);
    check_flag("instr_req_o.req", 1'b0, instr_req.req);

    test_name = "sequential";
    req   = 1'b1;
    ready = 1'b1;
    branch_to(32'h100);
    run_stream(N_SEQ, 100, 0);

    // targets in the upper half of a word
    test_name = "misaligned";
    for (int k = 0; k < 4; k++) begin
      branch_to((($urandom % 1024) * 4) + 2);
      run_stream(N_MIS / 4, 100, 0);
    end

    test_name = "branch abort";
    run_stream(N_ABORT, 75, 16);

    test_name = "back-pressure";
    branch_to(($urandom % 1024) * 4);
    run_stream(N_BP, 50, 0);

    // stream runs from 0x400 into the refused range at 0x440
    test_name = "bus error";
    err_lo = 12'h440;
    err_hi = 12'h480;
    branch_to(32'h400);
    @(negedge clk);
    branch = 1'b0;
    ready  = 1'b1;
    while (!fetch_failed) begin
      @(negedge clk);
    end
    // stuck on the refused access, so the FSM is not idle
    repeat (10) begin
      @(negedge clk);
      check_flag("valid_o after error", 1'b0, valid);
      check_flag("fetch_failed_o", 1'b1, fetch_failed);
      check_flag("busy_o in error", 1'b1, busy);
    end
    branch_to(32'h602);
    @(negedge clk);
    branch = 1'b0;
    check_flag("fetch_failed_o after branch", 1'b0, fetch_failed);
    run_stream(N_ERR - 20, 100, 0);
    err_lo = 12'h000;
    err_hi = 12'h000;

    // only the branch target is fetched with req low
    test_name = "idle status";
    req = 1'b0;
    branch_to(($urandom % 1024) * 4);
    @(negedge clk);
    branch = 1'b0;
    ready  = 1'b1;
    while (!valid) begin
      @(negedge clk);
    end
    while (valid) begin
      @(negedge clk);
    end
    check_flag("busy_o", 1'b0, busy);
    check_flag("instr_req_o.req", 1'b0, instr_req.req);
    check_flag("fetch_failed_o", 1'b0, fetch_failed);

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: flist.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_fifo.sv
verilog/prefetch_buffer.sv
verilog/if_stage.sv
verification/instr_mem_model.sv
verification/tb_if_stage.sv

// File: Bender.yml
package:
  name: if_stage

sources:
  # fetch front end RTL
  - include_dirs:
      - verilog
    files:
      - verilog/fetch_pkg.sv
      - verilog/fetch_fifo.sv
      - verilog/prefetch_buffer.sv
      - verilog/if_stage.sv

  # testbench and memory model
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/instr_mem_model.sv
      - verification/tb_if_stage.sv
